/* src/pf_pkg.sv */
// Shared widths, slice count and slice state type for the stride prefetch controller
`default_nettype none

package pf_pkg;

    localparam int ADDR_BITS  = 32;  // Byte address
    localparam int LEN_BITS   = 8;   // AXI burst length
    localparam int ID_BITS    = 4;   // AXI transaction ID
    localparam int NUM_SLICES = 4;
    localparam int SLICE_BITS = 2;   // Index into the slices
    localparam int WIN_BITS   = 4;   // Window size and outstanding count
    localparam int WD_BITS    = 10;  // Watchdog limit and counter

    // Per-stream learning states
    typedef enum logic [1:0] {
        PF_IDLE    = 2'd0,
        PF_ARM     = 2'd1,
        PF_ACTIVE  = 2'd2,
        PF_CLEANUP = 2'd3
    } pf_state_e;

endpackage

`default_nettype wire

/* src/pf_dispatch.sv */
// Demand dispatcher: slice lookup and allocation, hit report and missed demand register
`timescale 1ns/1ps
`default_nettype none

module pf_dispatch import pf_pkg::*; (
    input  logic                                 clk,
    input  logic                                 resetN,
    input  logic                                 en,
    input  logic                                 s_ar_valid,
    input  logic [ADDR_BITS-1:0]                 s_ar_addr,
    input  logic [LEN_BITS-1:0]                  s_ar_len,
    input  logic [ID_BITS-1:0]                   s_ar_id,
    input  logic [NUM_SLICES-1:0]                owned,
    input  logic [NUM_SLICES-1:0][ID_BITS-1:0]   owned_id,
    input  logic [NUM_SLICES-1:0]                demand_hit,
    input  logic                                 dem_grant,
    output logic                                 s_ar_ready,
    output logic [NUM_SLICES-1:0]                req_valid,
    output logic [ADDR_BITS-1:0]                 req_addr,
    output logic [LEN_BITS-1:0]                  req_len,
    output logic [ID_BITS-1:0]                   req_id,
    output logic                                 alloc,
    output logic                                 hit,
    output logic [ID_BITS-1:0]                   hit_id,
    output logic                                 dem_valid,
    output logic [ADDR_BITS-1:0]                 dem_addr,
    output logic [LEN_BITS-1:0]                  dem_len,
    output logic [ID_BITS-1:0]                   dem_id
);

    logic                  accept;
    logic                  any_hit;
    logic                  match_any, free_any;
    logic [SLICE_BITS-1:0] match_idx, free_idx;

    assign s_ar_ready = en && !dem_valid;  // Back-pressure while a demand waits
    assign accept     = s_ar_valid && s_ar_ready;
    assign any_hit    = |demand_hit;

    assign req_addr = s_ar_addr;
    assign req_len  = s_ar_len;
    assign req_id   = s_ar_id;

    // Scan from the top so the lowest index wins
    always_comb begin
        match_any = 1'b0;
        match_idx = '0;
        free_any  = 1'b0;
        free_idx  = '0;
        for (int i = NUM_SLICES - 1; i >= 0; i--) begin
            if (owned[i] && owned_id[i] == s_ar_id) begin
                match_any = 1'b1;
                match_idx = SLICE_BITS'(i);
            end
            if (!owned[i]) begin
                free_any = 1'b1;
                free_idx = SLICE_BITS'(i);
            end
        end
    end

    always_comb begin
        req_valid = '0;
        alloc     = 1'b0;
        if (accept) begin
            if (match_any) begin
                req_valid[match_idx] = 1'b1;
            end else if (free_any) begin
                req_valid[free_idx] = 1'b1;  // New stream takes the free slice
                alloc               = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            hit       <= 1'b0;
            dem_valid <= 1'b0;
        end else begin
            hit <= accept && any_hit;  // One pulse per absorbed demand
            if (accept && !any_hit) begin
                dem_valid <= 1'b1;
            end else if (dem_grant) begin
                dem_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            hit_id <= s_ar_id;
        end
        if (accept && !any_hit) begin
            dem_addr <= s_ar_addr;
            dem_len  <= s_ar_len;
            dem_id   <= s_ar_id;
        end
    end

endmodule

`default_nettype wire

/* src/pf_slice.sv */
// Prefetch slice: stride learning FSM, prefetch address generation, window count and watchdog
`timescale 1ns/1ps
`default_nettype none

module pf_slice import pf_pkg::*; (
    input  logic                 clk,
    input  logic                 resetN,
    input  logic                 en,
    input  logic                 flush,
    input  logic [ADDR_BITS-1:0] bar,
    input  logic [ADDR_BITS-1:0] limit,
    input  logic [WIN_BITS-1:0]  window_size,
    input  logic [WD_BITS-1:0]   watchdog_limit,
    input  logic                 req_valid,
    input  logic                 alloc,
    input  logic [ADDR_BITS-1:0] req_addr,
    input  logic [LEN_BITS-1:0]  req_len,
    input  logic [ID_BITS-1:0]   req_id,
    input  logic                 pf_grant,
    output logic                 owned,
    output logic [ID_BITS-1:0]   owned_id,
    output logic                 demand_hit,
    output logic                 pf_req,
    output logic [ADDR_BITS-1:0] pf_addr,
    output logic [LEN_BITS-1:0]  pf_len,
    output logic [ID_BITS-1:0]   pf_id,
    output pf_state_e            state
);

    pf_state_e            state_next;
    logic [ADDR_BITS-1:0] last_addr, last_addr_next;  // Demand seen while armed
    logic [LEN_BITS-1:0]  len_q, len_next;
    logic [ID_BITS-1:0]   id_q, id_next;
    logic [ADDR_BITS-1:0] stride, stride_next;
    logic [ADDR_BITS-1:0] head, head_next;            // Next block the stream will demand
    logic [ADDR_BITS-1:0] next_addr, next_addr_next;  // Next block to prefetch
    logic [WIN_BITS-1:0]  count, count_next;          // Prefetched and not yet consumed
    logic [WD_BITS-1:0]   wd_cnt, wd_cnt_next;

    logic [ADDR_BITS-1:0] diff;
    logic                 at_head;
    logic                 in_range;
    logic                 wd_expired;

    assign diff       = req_addr - last_addr;  // Wraps for negative strides
    assign at_head    = (req_addr == head) && (req_len == len_q);
    assign in_range   = (next_addr >= bar) && (next_addr < limit);
    assign wd_expired = (wd_cnt == watchdog_limit) && !req_valid;

    // Held through cleanup so the slice is not reallocated mid-teardown
    assign owned    = (state != PF_IDLE);
    assign owned_id = id_q;

    assign demand_hit = req_valid && (state == PF_ACTIVE) && at_head && (count != '0);

    // Yields to a demand on this stream for that cycle
    assign pf_req  = (state == PF_ACTIVE) && (count < window_size) && in_range && !req_valid;
    assign pf_addr = next_addr;
    assign pf_len  = len_q;
    assign pf_id   = id_q;

    always_comb begin
        state_next     = state;
        last_addr_next = last_addr;
        len_next       = len_q;
        id_next        = id_q;
        stride_next    = stride;
        head_next      = head;
        next_addr_next = next_addr;
        count_next     = count;
        wd_cnt_next    = req_valid ? '0 : wd_cnt + 1'b1;

        case (state)
            PF_IDLE: begin
                wd_cnt_next = '0;
                if (req_valid && alloc && !flush) begin
                    state_next     = PF_ARM;
                    last_addr_next = req_addr;
                    len_next       = req_len;
                    id_next        = req_id;
                end
            end

            PF_ARM: begin
                if (flush || wd_expired) begin
                    state_next = PF_CLEANUP;
                end else if (req_valid) begin
                    if (req_len != len_q) begin
                        state_next = PF_CLEANUP;  // Length change
                    end else if (diff != '0) begin
                        stride_next    = diff;
                        head_next      = req_addr + diff;
                        next_addr_next = req_addr + diff;
                        count_next     = '0;
                        state_next     = PF_ACTIVE;
                    end
                end
            end

            PF_ACTIVE: begin
                if (flush || wd_expired) begin
                    state_next = PF_CLEANUP;
                end else if (req_valid) begin
                    if (!at_head) begin
                        state_next = PF_CLEANUP;  // Stride break or length change
                    end else if (count != '0) begin
                        count_next = count - 1'b1;
                        head_next  = head + stride;
                    end else begin
                        // Demand overtook the prefetcher, skip past it
                        head_next      = head + stride;
                        next_addr_next = next_addr + stride;
                    end
                end else if (pf_grant) begin
                    next_addr_next = next_addr + stride;
                    count_next     = count + 1'b1;
                end
            end

            PF_CLEANUP: begin
                state_next  = PF_IDLE;
                count_next  = '0;
                wd_cnt_next = '0;
            end

            default: state_next = PF_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            state  <= PF_IDLE;
            count  <= '0;
            wd_cnt <= '0;
        end else if (en) begin
            state  <= state_next;
            count  <= count_next;
            wd_cnt <= wd_cnt_next;
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            last_addr <= last_addr_next;
            len_q     <= len_next;
            id_q      <= id_next;
            stride    <= stride_next;
            head      <= head_next;
            next_addr <= next_addr_next;
        end
    end

endmodule

`default_nettype wire

/* src/pf_arbiter.sv */
// Master AR arbiter: demand priority, round-robin over slices, registered output
`timescale 1ns/1ps
`default_nettype none

module pf_arbiter import pf_pkg::*; (
    input  logic                                 clk,
    input  logic                                 resetN,
    input  logic                                 en,
    input  logic                                 dem_valid,
    input  logic [ADDR_BITS-1:0]                 dem_addr,
    input  logic [LEN_BITS-1:0]                  dem_len,
    input  logic [ID_BITS-1:0]                   dem_id,
    input  logic [NUM_SLICES-1:0]                pf_req,
    input  logic [NUM_SLICES-1:0][ADDR_BITS-1:0] pf_addr,
    input  logic [NUM_SLICES-1:0][LEN_BITS-1:0]  pf_len,
    input  logic [NUM_SLICES-1:0][ID_BITS-1:0]   pf_id,
    input  logic                                 m_ar_ready,
    output logic                                 dem_grant,
    output logic [NUM_SLICES-1:0]                pf_grant,
    output logic                                 m_ar_valid,
    output logic [ADDR_BITS-1:0]                 m_ar_addr,
    output logic [LEN_BITS-1:0]                  m_ar_len,
    output logic [ID_BITS-1:0]                   m_ar_id,
    output logic                                 m_ar_prefetch
);

    logic                  load_ok;
    logic                  pf_any;
    logic [SLICE_BITS-1:0] rr_ptr;
    logic [SLICE_BITS-1:0] winner;

    assign load_ok   = en && (!m_ar_valid || m_ar_ready);  // Output empty or leaving
    assign dem_grant = load_ok && dem_valid;

    // First requester at or after the pointer
    always_comb begin
        logic [SLICE_BITS-1:0] idx;
        pf_any = 1'b0;
        winner = '0;
        for (int k = NUM_SLICES - 1; k >= 0; k--) begin
            idx = rr_ptr + SLICE_BITS'(k);
            if (pf_req[idx]) begin
                pf_any = 1'b1;
                winner = idx;
            end
        end
    end

    always_comb begin
        pf_grant = '0;
        if (load_ok && !dem_valid && pf_any) begin
            pf_grant[winner] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            m_ar_valid <= 1'b0;
            rr_ptr     <= '0;
        end else if (load_ok) begin
            m_ar_valid <= dem_valid || pf_any;
            if (!dem_valid && pf_any) begin
                rr_ptr <= winner + 1'b1;
            end
        end else if (m_ar_valid && m_ar_ready) begin
            m_ar_valid <= 1'b0;  // Handshake still completes with en low
        end
    end

    always_ff @(posedge clk) begin
        if (load_ok) begin
            if (dem_valid) begin
                m_ar_addr     <= dem_addr;
                m_ar_len      <= dem_len;
                m_ar_id       <= dem_id;
                m_ar_prefetch <= 1'b0;
            end else if (pf_any) begin
                m_ar_addr     <= pf_addr[winner];
                m_ar_len      <= pf_len[winner];
                m_ar_id       <= pf_id[winner];
                m_ar_prefetch <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* src/pf_top.sv */
// Prefetch controller top: dispatcher, slice array and master AR arbiter
`timescale 1ns/1ps
`default_nettype none

module pf_top import pf_pkg::*; (
    input  logic                       clk,
    input  logic                       resetN,
    input  logic                       en,
    input  logic                       flush,
    input  logic [ADDR_BITS-1:0]       bar,
    input  logic [ADDR_BITS-1:0]       limit,
    input  logic [WIN_BITS-1:0]        window_size,
    input  logic [WD_BITS-1:0]         watchdog_limit,
    input  logic                       s_ar_valid,
    input  logic [ADDR_BITS-1:0]       s_ar_addr,
    input  logic [LEN_BITS-1:0]        s_ar_len,
    input  logic [ID_BITS-1:0]         s_ar_id,
    input  logic                       m_ar_ready,
    output logic                       s_ar_ready,
    output logic                       m_ar_valid,
    output logic [ADDR_BITS-1:0]       m_ar_addr,
    output logic [LEN_BITS-1:0]        m_ar_len,
    output logic [ID_BITS-1:0]         m_ar_id,
    output logic                       m_ar_prefetch,
    output logic                       hit,
    output logic [ID_BITS-1:0]         hit_id,
    output pf_state_e [NUM_SLICES-1:0] slice_state
);

    // Dispatcher broadcast
    logic [NUM_SLICES-1:0]                req_valid;
    logic [ADDR_BITS-1:0]                 req_addr;
    logic [LEN_BITS-1:0]                  req_len;
    logic [ID_BITS-1:0]                   req_id;
    logic                                 alloc;

    // Slice status and prefetch requests
    logic [NUM_SLICES-1:0]                owned;
    logic [NUM_SLICES-1:0][ID_BITS-1:0]   owned_id;
    logic [NUM_SLICES-1:0]                demand_hit;
    logic [NUM_SLICES-1:0]                pf_req;
    logic [NUM_SLICES-1:0][ADDR_BITS-1:0] pf_addr;
    logic [NUM_SLICES-1:0][LEN_BITS-1:0]  pf_len;
    logic [NUM_SLICES-1:0][ID_BITS-1:0]   pf_id;
    logic [NUM_SLICES-1:0]                pf_grant;

    // Missed demand waiting for the master port
    logic                                 dem_valid;
    logic [ADDR_BITS-1:0]                 dem_addr;
    logic [LEN_BITS-1:0]                  dem_len;
    logic [ID_BITS-1:0]                   dem_id;
    logic                                 dem_grant;

    pf_dispatch u_dispatch (
        .clk        (clk),
        .resetN     (resetN),
        .en         (en),
        .s_ar_valid (s_ar_valid),
        .s_ar_addr  (s_ar_addr),
        .s_ar_len   (s_ar_len),
        .s_ar_id    (s_ar_id),
        .owned      (owned),
        .owned_id   (owned_id),
        .demand_hit (demand_hit),
        .dem_grant  (dem_grant),
        .s_ar_ready (s_ar_ready),
        .req_valid  (req_valid),
        .req_addr   (req_addr),
        .req_len    (req_len),
        .req_id     (req_id),
        .alloc      (alloc),
        .hit        (hit),
        .hit_id     (hit_id),
        .dem_valid  (dem_valid),
        .dem_addr   (dem_addr),
        .dem_len    (dem_len),
        .dem_id     (dem_id)
    );

    for (genvar i = 0; i < NUM_SLICES; i++) begin : g_slice
        pf_slice u_slice (
            .clk            (clk),
            .resetN         (resetN),
            .en             (en),
            .flush          (flush),
            .bar            (bar),
            .limit          (limit),
            .window_size    (window_size),
            .watchdog_limit (watchdog_limit),
            .req_valid      (req_valid[i]),
            .alloc          (alloc),
            .req_addr       (req_addr),
            .req_len        (req_len),
            .req_id         (req_id),
            .pf_grant       (pf_grant[i]),
            .owned          (owned[i]),
            .owned_id       (owned_id[i]),
            .demand_hit     (demand_hit[i]),
            .pf_req         (pf_req[i]),
            .pf_addr        (pf_addr[i]),
            .pf_len         (pf_len[i]),
            .pf_id          (pf_id[i]),
            .state          (slice_state[i])
        );
    end

    pf_arbiter u_arbiter (
        .clk           (clk),
        .resetN        (resetN),
        .en            (en),
        .dem_valid     (dem_valid),
        .dem_addr      (dem_addr),
        .dem_len       (dem_len),
        .dem_id        (dem_id),
        .pf_req        (pf_req),
        .pf_addr       (pf_addr),
        .pf_len        (pf_len),
        .pf_id         (pf_id),
        .m_ar_ready    (m_ar_ready),
        .dem_grant     (dem_grant),
        .pf_grant      (pf_grant),
        .m_ar_valid    (m_ar_valid),
        .m_ar_addr     (m_ar_addr),
        .m_ar_len      (m_ar_len),
        .m_ar_id       (m_ar_id),
        .m_ar_prefetch (m_ar_prefetch)
    );

endmodule

`default_nettype wire

/* dv/pf_tb_tasks.svh */
// Compare tasks, AR drive and expect tasks, and the directed tests of pf_tb
`ifndef PF_TB_TASKS_SVH
`define PF_TB_TASKS_SVH

task automatic compare_addr(input string name, input logic [ADDR_BITS-1:0] got,
                            input logic [ADDR_BITS-1:0] exp);
    if (got !== exp) begin
        abort_run($sformatf("** Error at %0t: %s is %h, expected %h", $time, name, got, exp));
    end
endtask

task automatic compare_len(input string name, input logic [LEN_BITS-1:0] got,
                           input logic [LEN_BITS-1:0] exp);
    if (got !== exp) begin
        abort_run($sformatf("** Error at %0t: %s is %h, expected %h", $time, name, got, exp));
    end
endtask

task automatic compare_id(input string name, input logic [ID_BITS-1:0] got,
                          input logic [ID_BITS-1:0] exp);
    if (got !== exp) begin
        abort_run($sformatf("** Error at %0t: %s is %h, expected %h", $time, name, got, exp));
    end
endtask

task automatic compare_state(input string name, input pf_state_e got, input pf_state_e exp);
    if (got !== exp) begin
        abort_run($sformatf("** Error at %0t: %s is %s, expected %s",
                            $time, name, got.name(), exp.name()));
    end
endtask

task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        abort_run($sformatf("** Error at %0t: %s is %b, expected %b", $time, name, got, exp));
    end
endtask

task automatic compare_count(input string name, input int got, input int exp);
    if (got != exp) begin
        abort_run($sformatf("** Error at %0t: %s is %0d, expected %0d", $time, name, got, exp));
    end
endtask

// Starts and ends on a falling edge
task automatic send_read(input logic [ADDR_BITS-1:0] addr, input logic [ID_BITS-1:0] id,
                         output int accept_cyc);
    int waited = 0;
    s_ar_valid = 1'b1;
    s_ar_addr  = addr;
    s_ar_len   = BURST_LEN;
    s_ar_id    = id;
    while (!s_ar_ready) begin
        @(negedge clk);
        waited++;
        if (waited > 64) begin
            abort_run("The slave AR port stayed busy for 64 cycles");
        end
    end
    accept_cyc = cycle_cnt;
    @(negedge clk);
    s_ar_valid = 1'b0;
endtask

// A negative exp_cyc skips the latency check
task automatic expect_ar(input logic [ADDR_BITS-1:0] exp_addr,
                         input logic [ID_BITS-1:0] exp_id,
                         input logic exp_pf, input int exp_cyc);
    int waited = 0;
    int got_cyc;
    while (ar_addr_q.size() == 0) begin
        @(negedge clk);
        waited++;
        if (waited > 64) begin
            abort_run($sformatf("No request reached m_ar, waiting for address %h", exp_addr));
        end
    end
    got_cyc = ar_cyc_q.pop_front();
    compare_addr("m_ar_addr", ar_addr_q.pop_front(), exp_addr);
    compare_len("m_ar_len", ar_len_q.pop_front(), BURST_LEN);
    compare_id("m_ar_id", ar_id_q.pop_front(), exp_id);
    compare_bit("m_ar_prefetch", ar_pf_q.pop_front(), exp_pf);
    if (exp_cyc >= 0) begin
        compare_count("m_ar accept cycle", got_cyc, exp_cyc);
    end
endtask

task automatic expect_quiet(input int cycles);
    repeat (cycles) @(negedge clk);
    compare_count("extra m_ar requests", ar_addr_q.size(), 0);
endtask

// Call right after send_read returns
task automatic expect_hit(input logic [ID_BITS-1:0] exp_id);
    compare_bit("hit", hit, 1'b1);
    compare_id("hit_id", hit_id, exp_id);
    @(negedge clk);
    compare_bit("hit", hit, 1'b0);  // Single cycle pulse
endtask

task automatic expect_state(input logic [SLICE_BITS-1:0] idx, input pf_state_e exp);
    compare_state($sformatf("slice_state[%0d]", idx), slice_state[idx], exp);
endtask

task automatic check_after_reset();
    for (int i = 0; i < NUM_SLICES; i++) begin
        expect_state(SLICE_BITS'(i), PF_IDLE);
    end
    compare_bit("m_ar_valid", m_ar_valid, 1'b0);
    compare_bit("hit", hit, 1'b0);
    compare_bit("s_ar_ready", s_ar_ready, 1'b1);
endtask

// Two demands teach the stride and exactly one window of prefetches follows
task automatic learn_stream(input logic [ADDR_BITS-1:0] base,
                            input logic [ADDR_BITS-1:0] stride,
                            input logic [ID_BITS-1:0] id);
    int c0;
    int c1;
    send_read(base, id, c0);
    send_read(base + stride, id, c1);
    expect_ar(base, id, 1'b0, c0 + 2);
    expect_ar(base + stride, id, 1'b0, c1 + 2);
    for (int i = 2; i < 2 + int'(WINDOW); i++) begin
        expect_ar(base + stride * i, id, 1'b1, -1);
    end
    expect_state(2'd0, PF_ACTIVE);
    expect_quiet(16);
endtask

task automatic absorb_hit();
    int c;
    send_read(STREAM_A + 2 * STRIDE_A, 4'd1, c);
    expect_hit(4'd1);
    // Freed slot refills past the end of the window
    expect_ar(STREAM_A + (32'd2 + 32'(WINDOW)) * STRIDE_A, 4'd1, 1'b1, -1);
    expect_quiet(16);
endtask

task automatic clean_up_streams();
    int c;
    int waited = 0;
    send_read(STREAM_A + 32'h24, 4'd1, c);  // Off the stride
    expect_state(2'd0, PF_CLEANUP);
    @(negedge clk);
    expect_state(2'd0, PF_IDLE);
    expect_ar(STREAM_A + 32'h24, 4'd1, 1'b0, c + 2);
    expect_quiet(16);

    learn_stream(STREAM_A + 32'h1000, STRIDE_A, 4'd1);
    flush = 1'b1;
    @(negedge clk);
    expect_state(2'd0, PF_CLEANUP);
    flush = 1'b0;
    @(negedge clk);
    expect_state(2'd0, PF_IDLE);
    expect_quiet(16);

    // Watchdog expiry with the stream left idle
    watchdog_limit = WD_SHORT;
    learn_stream(STREAM_A + 32'h2000, STRIDE_A, 4'd1);
    while (slice_state[0] != PF_CLEANUP) begin
        @(negedge clk);
        waited++;
        if (waited > 2 * int'(WD_SHORT)) begin
            abort_run("The watchdog never moved slice 0 to cleanup");
        end
    end
    @(negedge clk);
    expect_state(2'd0, PF_IDLE);
    expect_quiet(16);
    watchdog_limit = WD_LONG;
endtask

task automatic interleave_under_backpressure();
    logic [ADDR_BITS-1:0] base[2];
    logic [ADDR_BITS-1:0] stride[2];
    logic [ADDR_BITS-1:0] dem_next[2];
    logic [ADDR_BITS-1:0] pf_next[2];
    int                   dem_cnt[2];
    int                   pf_cnt[2];
    int                   c;
    logic                 k;
    logic [ADDR_BITS-1:0] addr;
    logic [LEN_BITS-1:0]  len;
    logic [ID_BITS-1:0]   id;
    logic                 is_pf;
    base       = '{STREAM_A + 32'h3000, STREAM_B};
    stride     = '{STRIDE_A, STRIDE_B};
    dem_next   = base;
    pf_next[0] = base[0] + 2 * stride[0];
    pf_next[1] = base[1] + 2 * stride[1];
    dem_cnt    = '{0, 0};
    pf_cnt     = '{0, 0};

    random_ready = 1'b1;
    send_read(base[0], 4'd1, c);
    send_read(base[1], 4'd2, c);
    send_read(base[0] + stride[0], 4'd1, c);
    send_read(base[1] + stride[1], 4'd2, c);
    repeat (120) begin
        @(negedge clk);
        while (ar_addr_q.size() != 0) begin
            addr  = ar_addr_q.pop_front();
            len   = ar_len_q.pop_front();
            id    = ar_id_q.pop_front();
            is_pf = ar_pf_q.pop_front();
            c     = ar_cyc_q.pop_front();
            if (id != 4'd1 && id != 4'd2) begin
                abort_run($sformatf("** Error at %0t: m_ar_id is %h, expected 1 or 2",
                                    $time, id));
            end
            if (addr < BAR_ADDR || addr >= LIMIT_ADDR) begin
                abort_run($sformatf("** Error at %0t: m_ar_addr is %h, expected below %h",
                                    $time, addr, LIMIT_ADDR));
            end
            compare_len("m_ar_len", len, BURST_LEN);
            k = (id == 4'd2);
            if (is_pf) begin
                compare_addr("prefetch m_ar_addr", addr, pf_next[k]);
                pf_next[k] = pf_next[k] + stride[k];
                pf_cnt[k]++;
            end else begin
                compare_addr("demand m_ar_addr", addr, dem_next[k]);
                dem_next[k] = dem_next[k] + stride[k];
                dem_cnt[k]++;
            end
        end
    end
    random_ready = 1'b0;
    compare_count("ID 1 demands", dem_cnt[0], 2);
    compare_count("ID 2 demands", dem_cnt[1], 2);
    compare_count("ID 1 prefetches", pf_cnt[0], int'(WINDOW));
    compare_count("ID 2 prefetches", pf_cnt[1], 2);  // Limit stops the window early
endtask

`endif

/* dv/pf_tb.sv */
// Testbench top with clock, reset, DUT, timeout, DDR ready model, AR monitor and test sequence
`timescale 1ns/1ps
`default_nettype none

module pf_tb import pf_pkg::*; ();

    localparam logic [ADDR_BITS-1:0] BAR_ADDR   = 32'h0000_1000;
    localparam logic [ADDR_BITS-1:0] LIMIT_ADDR = 32'h0000_6000;
    localparam logic [WIN_BITS-1:0]  WINDOW     = 4'd4;
    localparam logic [WD_BITS-1:0]   WD_LONG    = 10'd200;
    localparam logic [WD_BITS-1:0]   WD_SHORT   = 10'd40;
    localparam logic [LEN_BITS-1:0]  BURST_LEN  = 8'd3;
    localparam logic [ADDR_BITS-1:0] STREAM_A   = 32'h0000_2000;
    localparam logic [ADDR_BITS-1:0] STRIDE_A   = 32'h0000_0040;
    localparam logic [ADDR_BITS-1:0] STREAM_B   = 32'h0000_5F00;  // Room for two prefetches below the limit
    localparam logic [ADDR_BITS-1:0] STRIDE_B   = 32'h0000_0040;

    // Rough cycle budget per test
    localparam int RESET_LEN   = 4;
    localparam int LEARN_LEN   = 40;
    localparam int HIT_LEN     = 30;
    localparam int CLEANUP_LEN = 170;
    localparam int RANDOM_LEN  = 150;
    localparam int TIMEOUT_CYCLES =
        4 * (RESET_LEN + LEARN_LEN + HIT_LEN + CLEANUP_LEN + RANDOM_LEN);

    logic                       clk;
    logic                       resetN;
    logic                       en;
    logic                       flush;
    logic [ADDR_BITS-1:0]       bar;
    logic [ADDR_BITS-1:0]       limit;
    logic [WIN_BITS-1:0]        window_size;
    logic [WD_BITS-1:0]         watchdog_limit;
    logic                       s_ar_valid;
    logic [ADDR_BITS-1:0]       s_ar_addr;
    logic [LEN_BITS-1:0]        s_ar_len;
    logic [ID_BITS-1:0]         s_ar_id;
    logic                       m_ar_ready = 1'b1;
    logic                       s_ar_ready;
    logic                       m_ar_valid;
    logic [ADDR_BITS-1:0]       m_ar_addr;
    logic [LEN_BITS-1:0]        m_ar_len;
    logic [ID_BITS-1:0]         m_ar_id;
    logic                       m_ar_prefetch;
    logic                       hit;
    logic [ID_BITS-1:0]         hit_id;
    pf_state_e [NUM_SLICES-1:0] slice_state;

    int                   cycle_cnt    = 0;
    logic                 random_ready = 1'b0;
    logic [31:0]          rng_state    = 32'haad5e8ae;
    logic [ADDR_BITS-1:0] ar_addr_q[$];  // Accepted master AR requests in order
    logic [LEN_BITS-1:0]  ar_len_q[$];
    logic [ID_BITS-1:0]   ar_id_q[$];
    logic                 ar_pf_q[$];
    int                   ar_cyc_q[$];

    pf_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1, "Stopped at the first error");
    endtask

    // DDR takes a request every cycle unless the back-pressure test is running
    always @(negedge clk) begin
        if (random_ready) begin
            rng_state  = xorshift32(rng_state);
            m_ar_ready = rng_state[0];
        end else begin
            m_ar_ready = 1'b1;
        end
    end

    // AR monitor and cycle count
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (m_ar_valid && m_ar_ready) begin
            ar_addr_q.push_back(m_ar_addr);
            ar_len_q.push_back(m_ar_len);
            ar_id_q.push_back(m_ar_id);
            ar_pf_q.push_back(m_ar_prefetch);
            ar_cyc_q.push_back(cycle_cnt);  // Index of the accepting edge
        end
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("Timeout: the run went past %0d cycles", TIMEOUT_CYCLES));
        end
    end

`include "pf_tb_tasks.svh"

    initial begin
        resetN         = 1'b0;
        en             = 1'b1;
        flush          = 1'b0;
        bar            = BAR_ADDR;
        limit          = LIMIT_ADDR;
        window_size    = WINDOW;
        watchdog_limit = WD_LONG;
        s_ar_valid     = 1'b0;
        s_ar_addr      = '0;
        s_ar_len       = '0;
        s_ar_id        = '0;
        repeat (2) @(negedge clk);
        resetN = 1'b1;

        check_after_reset();
        learn_stream(STREAM_A, STRIDE_A, 4'd1);
        absorb_hit();
        clean_up_streams();
        interleave_under_backpressure();

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+dv
src/pf_pkg.sv
src/pf_dispatch.sv
src/pf_slice.sv
src/pf_arbiter.sv
src/pf_top.sv
dv/pf_tb.sv

/* Makefile */
# Verilator build and run of the stride prefetch controller testbench

SIM := obj_dir/Vpf_tb

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): src.f $(wildcard src/*.sv) $(wildcard dv/*.sv) $(wildcard dv/*.svh)
	verilator --binary --timing --top-module pf_tb -f src.f -o Vpf_tb

# The run passes only if the log holds the pass line
run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "^Done: no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log
